/* boardPkg.sv */
`default_nettype none

package boardPkg;

   // switch word as the harness reads it
   typedef struct packed
   {
      logic [3:0] rateSel;  // tick picked for the rate counter
      logic [3:0] dispSel;  // word shown on the display
      logic [7:0] user;     // free for the operator
   } switchFields;

   // the same sixteen switches, read raw or as fields
   typedef union packed
   {
      logic [15:0] raw;
      switchFields fields;
   } switchWord;

   // centre, up, down, left, right from msb to lsb
   typedef logic [4:0] buttonWord;

   // rate selection encoding
   localparam logic [3:0] RateSelEvery      = 4'd0;  // every clock
   localparam logic [3:0] RateSelBase       = 4'd1;  // prescaler tick
   localparam logic [3:0] RateSelFirstStage = 4'd2;  // stage k is this plus k

endpackage

`default_nettype wire

/* displayPkg.sv */
`default_nettype none

package displayPkg;

   localparam int NumDigits = 8;

   // active low, {dp, g, f, e, d, c, b, a}
   typedef logic [7:0] segWord;

   // display source encoding
   localparam logic [3:0] DispStageDigits = 4'd0;
   localparam logic [3:0] DispRateCount   = 4'd1;
   localparam logic [3:0] DispSwitches    = 4'd2;
   localparam logic [3:0] DispButtons     = 4'd3;

   function automatic segWord hexFont(input logic [3:0] nibble);
      logic [6:0] lit;  // segments on, gfedcba
      case (nibble)
         4'h0: lit = 7'h3F;
         4'h1: lit = 7'h06;
         4'h2: lit = 7'h5B;
         4'h3: lit = 7'h4F;
         4'h4: lit = 7'h66;
         4'h5: lit = 7'h6D;
         4'h6: lit = 7'h7D;
         4'h7: lit = 7'h07;
         4'h8: lit = 7'h7F;
         4'h9: lit = 7'h6F;
         4'hA: lit = 7'h77;
         4'hB: lit = 7'h7C;
         4'hC: lit = 7'h39;
         4'hD: lit = 7'h5E;
         4'hE: lit = 7'h79;
         default: lit = 7'h71;
      endcase
      return {1'b1, ~lit};  // decimal point off
   endfunction

endpackage

`default_nettype wire

/* inputSampler.sv */
`default_nettype none

module inputSampler
(
   input  logic                selected_clk,
   input  logic                res,
   input  logic                sampleTick,
   input  logic [15:0]         sw,
   input  boardPkg::buttonWord btn,
   output boardPkg::switchWord switches,
   output boardPkg::buttonWord buttons
);

   logic [15:0] swMeta;
   logic [15:0] swSync;
   logic [4:0]  btnMeta;
   logic [4:0]  btnSync;

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         swMeta  <= '0;
         swSync  <= '0;
         btnMeta <= '0;
         btnSync <= '0;
      end
      else
      begin
         swMeta  <= sw;      // first stage may go metastable
         swSync  <= swMeta;
         btnMeta <= btn;
         btnSync <= btnMeta;
      end
   end

   // slow capture, held between sample ticks
   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         switches.raw <= '0;
         buttons      <= '0;
      end
      else if (sampleTick)
      begin
         switches.raw <= swSync;
         buttons      <= btnSync;
      end
   end

endmodule

`default_nettype wire

/* tickPrescaler.sv */
`default_nettype none

module tickPrescaler
#(
   parameter int PrescaleDiv = 10
)
(
   input  logic selected_clk,
   input  logic res,
   output logic baseTick
);

   localparam int CntW = (PrescaleDiv > 1) ? $clog2(PrescaleDiv) : 1;

   logic [CntW-1:0] cnt;

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         cnt      <= CntW'(PrescaleDiv - 1);
         baseTick <= 1'b0;
      end
      else if (cnt == '0)
      begin
         cnt      <= CntW'(PrescaleDiv - 1);  // reload
         baseTick <= 1'b1;
      end
      else
      begin
         cnt      <= cnt - 1'b1;
         baseTick <= 1'b0;
      end
   end

endmodule

`default_nettype wire

/* decadeStage.sv */
`default_nettype none

module decadeStage
(
   input  logic       selected_clk,
   input  logic       res,
   input  logic       tickIn,
   output logic       tickOut,
   output logic [3:0] digit
);

   logic atNine;

   assign atNine  = (digit == 4'd9);
   assign tickOut = tickIn && atNine;  // carry to the next decade

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         digit <= 4'd0;
      end
      else if (tickIn)
      begin
         if (atNine)
         begin
            digit <= 4'd0;
         end
         else
         begin
            digit <= digit + 4'd1;
         end
      end
   end

endmodule

`default_nettype wire

/* rateCounter.sv */
`default_nettype none

module rateCounter
#(
   parameter int NumStages = 7
)
(
   input  logic                 selected_clk,
   input  logic                 res,
   input  logic [3:0]           rateSel,
   input  logic                 baseTick,
   input  logic [NumStages-1:0] stageTicks,
   output logic [31:0]          count
);

   import boardPkg::*;

   logic countEn;

   always_comb
   begin
      countEn = 1'b0;  // out of range selections count nothing
      if (rateSel == RateSelEvery)
         countEn = 1'b1;
      else if (rateSel == RateSelBase)
         countEn = baseTick;
      for (int k = 0; k < NumStages; k++)
         if (rateSel == 4'(RateSelFirstStage + k))
            countEn = stageTicks[k];
   end

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         count <= '0;
      end
      else if (countEn)
      begin
         count <= count + 32'd1;
      end
   end

endmodule

`default_nettype wire

/* displayDriver.sv */
`default_nettype none

module displayDriver
#(
   parameter int NumStages = 7
)
(
   input  logic                               selected_clk,
   input  logic                               res,
   input  logic                               scanTick,
   input  logic [3:0]                         dispSel,
   input  logic [4*NumStages-1:0]             stageDigits,
   input  logic [31:0]                        rateCount,
   input  boardPkg::switchWord                switches,
   input  boardPkg::buttonWord                buttons,
   output displayPkg::segWord                 seg,
   output logic [displayPkg::NumDigits-1:0]   an
);

   import displayPkg::*;

   localparam int WordW = 4 * NumDigits;
   localparam int IdxW  = $clog2(NumDigits);

   logic [WordW-1:0] stageWord;
   logic [WordW-1:0] selWord;
   logic [WordW-1:0] frame;
   logic [IdxW-1:0]  idx;
   logic             frameStart;
   logic             started;

   always_comb
   begin
      stageWord = '0;  // digits above the last stage stay zero
      for (int i = 0; i < NumStages; i++)
         stageWord[4*i +: 4] = stageDigits[4*i +: 4];
   end

   always_comb
   begin
      case (dispSel)
         DispStageDigits: selWord = stageWord;
         DispRateCount:   selWord = rateCount;
         DispSwitches:    selWord = WordW'(switches.raw);
         DispButtons:     selWord = WordW'(buttons);
         default:         selWord = '0;
      endcase
   end

   assign frameStart = scanTick && (idx == IdxW'(NumDigits - 1));

   // index starts on the last digit so the first tick opens a frame
   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         idx     <= IdxW'(NumDigits - 1);
         started <= 1'b0;
      end
      else if (scanTick)
      begin
         idx     <= idx + 1'b1;
         started <= 1'b1;
      end
   end

   always_ff @(posedge selected_clk)
   begin
      if (frameStart)
         frame <= selWord;  // whole frame from one cycle
   end

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         an  <= '1;
         seg <= '1;
      end
      else if (started)
      begin
         an  <= ~(NumDigits'(1) << idx);
         seg <= hexFont(frame[4*idx +: 4]);
      end
   end

endmodule

`default_nettype wire

/* boardTop.sv */
`default_nettype none

module boardTop
#(
   parameter int PrescaleDiv = 10,
   parameter int NumStages   = 7   // display shows at most 8
)
(
   input  logic        selected_clk,
   input  logic        res,
   input  logic [15:0] sw,
   input  logic [4:0]  btn,
   output logic [15:0] leds,
   output logic [7:0]  seg,
   output logic [7:0]  an
);

   import boardPkg::*;

   logic                   baseTick;
   logic [NumStages-1:0]   stageTicks;
   logic [NumStages:0]     tickChain;
   logic [4*NumStages-1:0] stageDigits;
   logic [31:0]            rateCount;
   switchWord              switches;
   buttonWord              buttons;

   assign tickChain = {stageTicks, baseTick};  // stage i is fed by entry i
   assign leds      = switches.raw;

   tickPrescaler #(.PrescaleDiv(PrescaleDiv)) prescaler
   (
      .selected_clk (selected_clk),
      .res          (res),
      .baseTick     (baseTick)
   );

   for (genvar i = 0; i < NumStages; i++)
   begin : gStage
      decadeStage stage
      (
         .selected_clk (selected_clk),
         .res          (res),
         .tickIn       (tickChain[i]),
         .tickOut      (stageTicks[i]),
         .digit        (stageDigits[4*i +: 4])
      );
   end

   inputSampler sampler
   (
      .selected_clk (selected_clk),
      .res          (res),
      .sampleTick   (stageTicks[0]),
      .sw           (sw),
      .btn          (btn),
      .switches     (switches),
      .buttons      (buttons)
   );

   rateCounter #(.NumStages(NumStages)) rateCnt
   (
      .selected_clk (selected_clk),
      .res          (res),
      .rateSel      (switches.fields.rateSel),
      .baseTick     (baseTick),
      .stageTicks   (stageTicks),
      .count        (rateCount)
   );

   displayDriver #(.NumStages(NumStages)) display
   (
      .selected_clk (selected_clk),
      .res          (res),
      .scanTick     (baseTick),
      .dispSel      (switches.fields.dispSel),
      .stageDigits  (stageDigits),
      .rateCount    (rateCount),
      .switches     (switches),
      .buttons      (buttons),
      .seg          (seg),
      .an           (an)
   );

endmodule

`default_nettype wire

/* tbBoard.sv */
`default_nettype none

module tbBoard;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int PrescaleDiv = 10;  // boardTop defaults
   localparam int NumStages   = 7;
   localparam int FrameCycles = 8 * PrescaleDiv;

   logic        selected_clk;
   logic        res;
   logic [15:0] sw;
   logic [4:0]  btn;
   logic [15:0] leds;
   logic [7:0]  seg;
   logic [7:0]  an;

   integer      seed;
   logic [31:0] rnd;

   // tick model, advanced once per clock after reset
   int          cyc = 0;
   int          tickCount = 0;
   int          scanIdx = 7;
   logic        scanStarted = 1'b0;
   logic [31:0] rateModel = '0;
   logic [31:0] latchedWord = '0;
   logic [7:0]  anExp = 8'hFF;
   logic [15:0] swMetaM = '0;
   logic [15:0] swSyncM = '0;
   logic [15:0] swModel = '0;
   logic [4:0]  btnMetaM = '0;
   logic [4:0]  btnSyncM = '0;
   logic [4:0]  btnModel = '0;

   // frame capture from an and seg
   logic [7:0]  captured [8];
   logic [7:0]  prevAn = 8'hFF;
   logic [31:0] shownWord = '0;
   logic        haveFrame = 1'b0;
   int          frameCount = 0;

   boardTop DUT
   (
      .selected_clk (selected_clk),
      .res          (res),
      .sw           (sw),
      .btn          (btn),
      .leds         (leds),
      .seg          (seg),
      .an           (an)
   );

   initial
   begin
      selected_clk = 1'b0;
      forever #2 selected_clk = ~selected_clk;
   end

   function automatic logic [7:0] fontOf(input logic [3:0] nibble);
      case (nibble)  // active low, dp off
         4'h0: return 8'hC0;
         4'h1: return 8'hF9;
         4'h2: return 8'hA4;
         4'h3: return 8'hB0;
         4'h4: return 8'h99;
         4'h5: return 8'h92;
         4'h6: return 8'h82;
         4'h7: return 8'hF8;
         4'h8: return 8'h80;
         4'h9: return 8'h90;
         4'hA: return 8'h88;
         4'hB: return 8'h83;
         4'hC: return 8'hC6;
         4'hD: return 8'hA1;
         4'hE: return 8'h86;
         default: return 8'h8E;
      endcase
   endfunction

   function automatic int pow10(input int k);
      int p;
      p = 1;
      for (int i = 0; i < k; i++)
         p = p * 10;
      return p;
   endfunction

   // stage k carries on the tick that completes a multiple of 10^(k+1)
   function automatic logic stageCarry(input int k, input int ticksBefore);
      return ((ticksBefore + 1) % pow10(k + 1)) == 0;
   endfunction

   function automatic logic [31:0] expectedWord(input logic [3:0] dispSel,
         input int tickCount, input logic [31:0] rateCount,
         input logic [15:0] switches, input logic [4:0] buttons);
      logic [31:0] word;
      word = '0;
      case (dispSel)
         4'd0:
            for (int i = 0; i < NumStages; i++)
               word[4*i +: 4] = 4'((tickCount / pow10(i)) % 10);  // bcd digits
         4'd1: word = rateCount;
         4'd2: word = {16'd0, switches};
         4'd3: word = {27'd0, buttons};
         default: word = '0;
      endcase
      return word;
   endfunction

   task automatic failCheck(input string msg);
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
      $display("*** TEST FAILED ***");
      $fatal(1, "check failed");
   endtask

   task automatic failTimeout(input string msg);
      $display("Timed out at %0t ns while waiting: %s", $time, msg);
      $display("*** TEST FAILED ***");
      $fatal(1, "timeout");
   endtask

   task automatic compareFrame();
      for (int i = 0; i < 8; i++)
         assert (captured[i] == fontOf(shownWord[4*i +: 4]))
            else failCheck($sformatf("digit %0d seg %h, word %h", i, captured[i], shownWord));
   endtask

   task automatic checkOutputs();
      int digit;
      digit = -1;
      assert (leds == swModel)
         else failCheck($sformatf("leds %h, expected %h", leds, swModel));
      assert (an == anExp)
         else failCheck($sformatf("an %b, expected %b", an, anExp));
      if (anExp == 8'hFF)
      begin
         assert (seg == 8'hFF)
            else failCheck($sformatf("seg %h before first scan", seg));
      end
      for (int i = 0; i < 8; i++)
         if (!an[i])
            digit = i;
      if (digit == 0 && prevAn != an)
      begin
         if (haveFrame)
            compareFrame();
         haveFrame = 1'b1;
         shownWord = latchedWord;  // latched one cycle earlier
         frameCount++;
      end
      if (digit >= 0)
         captured[digit] = seg;
      prevAn = an;
   endtask

   task automatic advanceModel();
      logic tick;
      logic inc;
      int   sel;
      tick = (cyc != 0) && (cyc % PrescaleDiv == 0);
      sel  = int'(swModel[15:12]);
      if (scanStarted)
         anExp = ~(8'b1 << scanIdx);
      if (tick && scanIdx == 7)
         latchedWord = expectedWord(swModel[11:8], tickCount, rateModel, swModel, btnModel);
      if (sel == 0)
         inc = 1'b1;
      else if (sel == 1)
         inc = tick;
      else if (sel - 2 < NumStages)
         inc = tick && stageCarry(sel - 2, tickCount);
      else
         inc = 1'b0;
      if (tick && stageCarry(0, tickCount))
      begin
         swModel  = swSyncM;  // capture on stage 0 tick
         btnModel = btnSyncM;
      end
      swSyncM  = swMetaM;
      swMetaM  = sw;
      btnSyncM = btnMetaM;
      btnMetaM = btn;
      if (tick)
      begin
         scanIdx     = (scanIdx + 1) % 8;
         scanStarted = 1'b1;
         tickCount++;
      end
      if (inc)
         rateModel++;
      cyc++;
   endtask

   always @(posedge selected_clk)
   begin
      if (!res)
      begin
         checkOutputs();
         advanceModel();
      end
   end

   task automatic waitFrames(input int n);
      int target;
      int t;
      target = frameCount + n;
      t = 0;
      while (frameCount < target)
      begin
         @(negedge selected_clk);
         t++;
         if (t > (n + 2) * FrameCycles)
            failTimeout("display frames stopped");
      end
   endtask

   task automatic waitLeds(input logic [15:0] value);
      int t;
      t = 0;
      while (leds !== value)
      begin
         @(negedge selected_clk);
         t++;
         if (t > 30 * PrescaleDiv)
            failTimeout("switch value never reached the leds");
      end
   endtask

   task automatic applySwitches(input logic [15:0] value);
      sw = value;
      waitLeds(value);
      waitFrames(3);  // a whole frame latched after the change
   endtask

   initial
   begin
      seed = 73424;
      res  = 1'b1;
      sw   = '0;
      btn  = '0;
      @(posedge selected_clk);
      @(negedge selected_clk);
      assert (an == 8'hFF && seg == 8'hFF && leds == 16'h0)
         else failCheck($sformatf("in reset an %h seg %h leds %h", an, seg, leds));
      @(negedge selected_clk);
      res = 1'b0;
      waitFrames(4);  // stage digits in bcd
      repeat (3)
      begin
         rnd = $random(seed);
         applySwitches({rnd[15:12], 4'd2, rnd[7:0]});
      end
      for (int sel = 0; sel < 3; sel++)
         applySwitches({4'(sel), 4'd1, 8'h00});
      rnd = $random(seed);
      btn = rnd[4:0];
      applySwitches(16'h0300);
      applySwitches(16'h0B00);  // no such source
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

/* boardTest.f */
boardPkg.sv
displayPkg.sv
inputSampler.sv
tickPrescaler.sv
decadeStage.sv
rateCounter.sv
displayDriver.sv
boardTop.sv
tbBoard.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbBoard
FILELIST  ?= boardTest.f
FLAGS     ?= --timing --assert
OBJDIR    ?= obj_dir
PASSTEXT  := *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASSTEXT)'

clean:
	rm -rf $(OBJDIR)
